// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam real HALF_PERIOD  = 2.0;
    localparam int  RESET_CYCLES = 10;

    initial
    begin
        clk = 1'b0;
        forever
            #HALF_PERIOD clk = ~clk;
    end

    // Release lands just after an edge, clear of the DUT sampling
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== bench/tb_digital_clock.sv ====
`timescale 1ns/1ps
`include "clock_macros.svh"

module tb_digital_clock;
    import clock_pkg::*;

    localparam int CYCLES_PER_SEC = `CLK_PER_CENTI * `CENTI_PER_SEC;
    localparam int MINUTE_WAIT    = 61 * CYCLES_PER_SEC;
    // Three minute-long waits and about 150 presses stay under 100000 cycles
    localparam int TIMEOUT_CYCLES = 200000;

    localparam int BTN_DOWN = 0;
    localparam int BTN_UP   = 1;
    localparam int BTN_SET  = 2;
    localparam int BTN_MODE = 3;

    logic        clk;
    logic        rst_n;
    logic [3:0]  buttons;
    screen_t     screen;
    flash_t      flash;
    field_t      disp_left;
    field_t      disp_mid;
    field_t      disp_right;

    logic [31:0] rng_state;
    int          cycle_count = 0;
    int          failures;
    screen_t     exp_screen;
    int          clk_h;
    int          clk_m;
    int          al_h;
    int          al_m;
    field_t      held_left;
    field_t      held_mid;
    field_t      held_right;

    clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    digital_clock DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .mode_btn   (buttons[BTN_MODE]),
        .set_btn    (buttons[BTN_SET]),
        .up_btn     (buttons[BTN_UP]),
        .down_btn   (buttons[BTN_DOWN]),
        .screen     (screen),
        .flash      (flash),
        .disp_left  (disp_left),
        .disp_mid   (disp_mid),
        .disp_right (disp_right)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and random numbers
    ////////////////////////////////////////////////////////////////////////////

    // Field value after a number of up and down steps, wrapping both ways
    function automatic int wrap_steps(int start, int up_count, int down_count, int limit);
        return ((start + up_count - down_count) % limit + limit) % limit;
    endfunction

    function automatic screen_t screen_after_mode(screen_t current);
        screen_t result;
        case (current)
            SCREEN_TIME:  result = SCREEN_ALARM;
            SCREEN_ALARM: result = SCREEN_STOPWATCH;
            default:      result = SCREEN_TIME;
        endcase
        return result;
    endfunction

    function automatic logic [31:0] xorshift32(logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_press_count(output int count);
        rng_state = xorshift32(rng_state);
        count = int'(rng_state % 30) + 1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        failures = failures + 1;
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_screen(screen_t expected);
        if (screen !== expected)
        begin
            $display("[FAIL] screen: expected 0x%h, got 0x%h", expected, screen);
            abort_run();
        end
    endtask

    task automatic check_flash(flash_t expected);
        if (flash !== expected)
        begin
            $display("[FAIL] flash: expected 0x%h, got 0x%h", expected, flash);
            abort_run();
        end
    endtask

    task automatic check_fields(field_t left, field_t mid, field_t right);
        if (disp_left !== left)
        begin
            $display("[FAIL] disp_left: expected 0x%h, got 0x%h", left, disp_left);
            abort_run();
        end
        if (disp_mid !== mid)
        begin
            $display("[FAIL] disp_mid: expected 0x%h, got 0x%h", mid, disp_mid);
            abort_run();
        end
        if (disp_right !== right)
        begin
            $display("[FAIL] disp_right: expected 0x%h, got 0x%h", right, disp_right);
            abort_run();
        end
    endtask

    // Stopwatch total in centiseconds, against a window around the expected count
    task automatic check_elapsed(centi_t expected, centi_t tolerance);
        int total;
        total = int'(disp_left) * 6000 + int'(disp_mid) * 100 + int'(disp_right);
        if (total < int'(expected) - int'(tolerance) || total > int'(expected) + int'(tolerance))
        begin
            $display("[FAIL] stopwatch total: expected 0x%h +/- 0x%h, got 0x%h",
                     expected, tolerance, total);
            abort_run();
        end
    endtask

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_cycles(int count);
        repeat (count)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic press_button(int index);
        buttons[index] = 1'b1;
        wait_cycles(8);
        buttons[index] = 1'b0;
        wait_cycles(8);
        wait_cycles(10);
    endtask

    task automatic press_repeated(int index, int count);
        repeat (count)
            press_button(index);
    endtask

    task automatic press_mode();
        press_button(BTN_MODE);
        exp_screen = screen_after_mode(exp_screen);
    endtask

    task automatic random_adjust(input int start, input int limit, output int result);
        int up_count;
        int down_count;
        draw_press_count(up_count);
        draw_press_count(down_count);
        press_repeated(BTN_UP, up_count);
        press_repeated(BTN_DOWN, down_count);
        result = wrap_steps(start, up_count, down_count, limit);
    endtask

    task automatic step_up_to(int start, int target, int limit);
        press_repeated(BTN_UP, wrap_steps(target, 0, start, limit));
    endtask

    // Polls the time shown, optionally making sure nothing rings meanwhile
    task automatic wait_for_time(field_t hours, field_t minutes, logic quiet);
        int waited;
        waited = 0;
        while (disp_left !== hours || disp_mid !== minutes)
        begin
            if (quiet)
                check_flash(3'b000);
            if (waited == MINUTE_WAIT)
            begin
                $display("Clock did not reach %0d:%0d within 61 seconds", hours, minutes);
                abort_run();
            end
            wait_cycles(1);
            waited = waited + 1;
        end
    endtask

    task automatic wait_for_flash(flash_t expected);
        int waited;
        waited = 0;
        while (flash !== expected)
        begin
            if (waited == MINUTE_WAIT)
            begin
                $display("Alarm did not ring within 61 seconds of arming");
                abort_run();
            end
            wait_cycles(1);
            waited = waited + 1;
        end
    endtask

    initial
    begin
        buttons    = '0;
        rng_state  = 32'h2225;
        failures   = 0;
        exp_screen = SCREEN_TIME;
        clk_h      = 0;
        clk_m      = 0;
        al_h       = 0;
        al_m       = 0;

        wait (rst_n === 1'b1);
        wait_cycles(1);

        // Reset state, then 3.5 s of running time
        check_screen(exp_screen);
        check_flash(3'b000);
        check_fields(0, 0, 0);
        wait_cycles(1750);
        check_fields(0, 0, 3);

        // Time setting
        press_button(BTN_SET);
        check_flash(3'b100);
        random_adjust(clk_h, `HOURS_PER_DAY, clk_h);
        check_fields(clk_h, clk_m, 0);
        check_flash(3'b100);
        step_up_to(clk_h, 23, `HOURS_PER_DAY);
        clk_h = 23;
        check_fields(clk_h, clk_m, 0);
        press_button(BTN_SET);
        check_flash(3'b010);
        random_adjust(clk_m, `MIN_PER_HOUR, clk_m);
        check_fields(clk_h, clk_m, 0);
        check_flash(3'b010);
        step_up_to(clk_m, 59, `MIN_PER_HOUR);
        clk_m = 59;
        check_fields(clk_h, clk_m, 0);
        press_button(BTN_SET);
        check_flash(3'b000);
        check_screen(exp_screen);
        wait_for_time(0, 0, 1'b0);
        clk_h = 0;
        clk_m = 0;
        check_fields(0, 0, 0);

        // Screen cycling
        press_mode();
        check_screen(exp_screen);
        check_fields(al_h, al_m, 0);
        press_mode();
        check_screen(exp_screen);
        check_fields(0, 0, 0);
        press_mode();
        check_screen(exp_screen);

        // Alarm one minute ahead of the clock
        press_mode();
        press_button(BTN_SET);
        check_flash(3'b100);
        step_up_to(al_h, (clk_m == 59) ? wrap_steps(clk_h, 1, 0, 24) : clk_h, 24);
        al_h = (clk_m == 59) ? wrap_steps(clk_h, 1, 0, 24) : clk_h;
        press_button(BTN_SET);
        check_flash(3'b010);
        step_up_to(al_m, wrap_steps(clk_m, 1, 0, 60), 60);
        al_m = wrap_steps(clk_m, 1, 0, 60);
        check_fields(al_h, al_m, 0);
        press_button(BTN_SET);
        check_screen(exp_screen);
        check_flash(3'b000);
        press_mode();
        press_mode();
        check_screen(exp_screen);
        wait_for_flash(3'b111);
        check_screen(SCREEN_TIME);
        check_fields(al_h, al_m, 0);
        press_button(BTN_DOWN);
        check_flash(3'b000);
        wait_for_time((al_m == 59) ? wrap_steps(al_h, 1, 0, 24) : al_h,
                      wrap_steps(al_m, 1, 0, 60), 1'b1);
        check_fields((al_m == 59) ? wrap_steps(al_h, 1, 0, 24) : al_h,
                     wrap_steps(al_m, 1, 0, 60), 0);

        // Stopwatch, 250 cycles between the two toggles
        press_mode();
        press_mode();
        check_screen(exp_screen);
        check_fields(0, 0, 0);
        press_button(BTN_SET);
        wait_cycles(224);
        press_button(BTN_SET);
        check_elapsed(50, 2);
        held_left  = disp_left;
        held_mid   = disp_mid;
        held_right = disp_right;
        wait_cycles(200);
        check_fields(held_left, held_mid, held_right);
        press_button(BTN_UP);
        check_fields(0, 0, 0);
        // About 147 running cycles when the display is read
        press_button(BTN_SET);
        wait_cycles(100);
        press_button(BTN_UP);
        check_elapsed(30, 2);
        press_button(BTN_SET);

        if (failures == 0)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            abort_run();
        end
    end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/clock_pkg.sv
rtl/tick_divider.sv
rtl/button_sync.sv
rtl/time_counter.sv
rtl/alarm_register.sv
rtl/stopwatch.sv
rtl/mode_fsm.sv
rtl/digital_clock.sv
bench/clock_gen.sv
bench/tb_digital_clock.sv

// ==== rtl/alarm_register.sv ====
`timescale 1ns/1ps
`include "clock_macros.svh"

module alarm_register (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                alarm_hours_sel,
    input  logic                alarm_minutes_sel,
    input  logic                up_press,
    input  logic                down_press,
    input  logic                arm,
    input  logic                disarm,
    input  clock_pkg::hours_t   clock_hours,
    input  clock_pkg::minutes_t clock_minutes,
    output clock_pkg::hours_t   alarm_hours,
    output clock_pkg::minutes_t alarm_minutes,
    output logic                armed,
    output logic                alarm_match
);
    import clock_pkg::*;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            alarm_hours   <= '0;
            alarm_minutes <= '0;
            armed         <= 1'b0;
        end
        else
        begin
            if ((up_press || down_press) && alarm_hours_sel)
                alarm_hours <= hours_t'(wrap_step(field_t'(alarm_hours),
                                                  field_t'(`HOURS_PER_DAY), up_press));
            else if ((up_press || down_press) && alarm_minutes_sel)
                alarm_minutes <= minutes_t'(wrap_step(field_t'(alarm_minutes),
                                                      field_t'(`MIN_PER_HOUR), up_press));

            // Silencing wins over a late arm
            if (disarm)
                armed <= 1'b0;
            else if (arm)
                armed <= 1'b1;
        end
    end

    assign alarm_match = armed && (alarm_hours == clock_hours)
                               && (alarm_minutes == clock_minutes);

endmodule

// ==== rtl/button_sync.sv ====
`timescale 1ns/1ps
`include "clock_macros.svh"

module button_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic mode_btn,
    input  logic set_btn,
    input  logic up_btn,
    input  logic down_btn,
    output logic mode_press,
    output logic set_press,
    output logic up_press,
    output logic down_press
);

    logic [3:0]                   raw;
    logic [`SYNC_STAGES-1:0][3:0] sync_q;
    logic [3:0]                   prev_q;
    logic [3:0]                   press_q;

    assign raw = {mode_btn, set_btn, up_btn, down_btn};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sync_q  <= '0;
            prev_q  <= '0;
            press_q <= '0;
        end
        else
        begin
            sync_q  <= {sync_q[`SYNC_STAGES-2:0], raw};
            prev_q  <= sync_q[`SYNC_STAGES-1];
            // Rising edge of the synchronized level
            press_q <= sync_q[`SYNC_STAGES-1] & ~prev_q;
        end
    end

    assign {mode_press, set_press, up_press, down_press} = press_q;

endmodule

// ==== rtl/clock_macros.svh ====
`ifndef CLOCK_MACROS_SVH
`define CLOCK_MACROS_SVH

// Prescaler, kept small so simulations stay short
`define CLK_PER_CENTI 5
`define CENTI_PER_SEC 100

// Wrap limits of the time fields
`define HOURS_PER_DAY 24
`define MIN_PER_HOUR  60
`define SEC_PER_MIN   60

// Stopwatch end of range, 59:59.99
`define SW_LAST_MIN   59
`define SW_LAST_SEC   59
`define SW_LAST_CENTI 99

`define SYNC_STAGES 2

`endif

// ==== rtl/clock_pkg.sv ====
package clock_pkg;

    typedef logic [4:0] hours_t;
    typedef logic [5:0] minutes_t;
    typedef logic [6:0] centi_t;
    typedef logic [6:0] field_t;

    // Bit 2 left, bit 1 middle, bit 0 right
    typedef logic [2:0] flash_t;

    typedef enum logic [1:0] {
        SCREEN_TIME,
        SCREEN_ALARM,
        SCREEN_STOPWATCH
    } screen_t;

    typedef enum logic [2:0] {
        ST_CLOCK,
        ST_SET_HOURS,
        ST_SET_MINUTES,
        ST_ALARM,
        ST_ALARM_HOURS,
        ST_ALARM_MINUTES,
        ST_STOPWATCH,
        ST_RINGING
    } clock_state_t;

    // One step up or down, wrapping at both ends of 0..limit-1
    function automatic field_t wrap_step(field_t value, field_t limit, logic up);
        field_t result;
        if (up)
            result = (value == limit - 7'd1) ? '0 : value + 7'd1;
        else
            result = (value == '0) ? limit - 7'd1 : value - 7'd1;
        return result;
    endfunction

endpackage

// ==== rtl/digital_clock.sv ====
`timescale 1ns/1ps

module digital_clock (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mode_btn,
    input  logic               set_btn,
    input  logic               up_btn,
    input  logic               down_btn,
    output clock_pkg::screen_t screen,
    output clock_pkg::flash_t  flash,
    output clock_pkg::field_t  disp_left,
    output clock_pkg::field_t  disp_mid,
    output clock_pkg::field_t  disp_right
);
    import clock_pkg::*;

    logic     centi_tick;
    logic     sec_tick;
    logic     mode_press;
    logic     set_press;
    logic     up_press;
    logic     down_press;
    logic     adjust_hours;
    logic     adjust_minutes;
    logic     alarm_hours_sel;
    logic     alarm_minutes_sel;
    logic     arm;
    logic     disarm;
    logic     sw_toggle;
    logic     sw_clear;
    logic     alarm_match;
    logic     alarm_armed;
    hours_t   clock_hours;
    minutes_t clock_minutes;
    minutes_t clock_seconds;
    hours_t   alarm_hours;
    minutes_t alarm_minutes;
    minutes_t sw_minutes;
    minutes_t sw_seconds;
    centi_t   sw_centis;

    ////////////////////////////////////////////////////////////////////////////
    // Ticks and buttons
    ////////////////////////////////////////////////////////////////////////////

    tick_divider u_tick_divider (.*);

    button_sync u_button_sync (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Value blocks
    ////////////////////////////////////////////////////////////////////////////

    time_counter u_time_counter (
        .clk            (clk),
        .rst_n          (rst_n),
        .sec_tick       (sec_tick),
        .adjust_hours   (adjust_hours),
        .adjust_minutes (adjust_minutes),
        .up_press       (up_press),
        .down_press     (down_press),
        .hours          (clock_hours),
        .minutes        (clock_minutes),
        .seconds        (clock_seconds)
    );

    alarm_register u_alarm_register (
        .clk               (clk),
        .rst_n             (rst_n),
        .alarm_hours_sel   (alarm_hours_sel),
        .alarm_minutes_sel (alarm_minutes_sel),
        .up_press          (up_press),
        .down_press        (down_press),
        .arm               (arm),
        .disarm            (disarm),
        .clock_hours       (clock_hours),
        .clock_minutes     (clock_minutes),
        .alarm_hours       (alarm_hours),
        .alarm_minutes     (alarm_minutes),
        .armed             (alarm_armed),
        .alarm_match       (alarm_match)
    );

    stopwatch u_stopwatch (.*);

    mode_fsm u_mode_fsm (.*);

    // Ringing shows only while armed, or in the cycle right after silencing
    a_ring_armed: assert property (@(posedge clk) disable iff (!rst_n)
        flash == 3'b111 |-> alarm_armed || $past(disarm))
    else
        $error("alarm ringing while disarmed");

endmodule

// ==== rtl/mode_fsm.sv ====
`timescale 1ns/1ps

module mode_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mode_press,
    input  logic                set_press,
    input  logic                up_press,
    input  logic                down_press,
    input  logic                alarm_match,
    input  clock_pkg::hours_t   clock_hours,
    input  clock_pkg::minutes_t clock_minutes,
    input  clock_pkg::minutes_t clock_seconds,
    input  clock_pkg::hours_t   alarm_hours,
    input  clock_pkg::minutes_t alarm_minutes,
    input  clock_pkg::minutes_t sw_minutes,
    input  clock_pkg::minutes_t sw_seconds,
    input  clock_pkg::centi_t   sw_centis,
    output logic                adjust_hours,
    output logic                adjust_minutes,
    output logic                alarm_hours_sel,
    output logic                alarm_minutes_sel,
    output logic                arm,
    output logic                disarm,
    output logic                sw_toggle,
    output logic                sw_clear,
    output clock_pkg::screen_t  screen,
    output clock_pkg::flash_t   flash,
    output clock_pkg::field_t   disp_left,
    output clock_pkg::field_t   disp_mid,
    output clock_pkg::field_t   disp_right
);
    import clock_pkg::*;

    clock_state_t state;
    clock_state_t next_state;
    screen_t      next_screen;
    flash_t       next_flash;
    field_t       next_left;
    field_t       next_mid;
    field_t       next_right;

    ////////////////////////////////////////////////////////////////////////////
    // Screen state machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        next_state = state;
        case (state)
            ST_CLOCK:
                if (mode_press)
                    next_state = ST_ALARM;
                else if (set_press)
                    next_state = ST_SET_HOURS;
                else if (alarm_match)
                    next_state = ST_RINGING;
            ST_SET_HOURS, ST_SET_MINUTES:
                if (mode_press)
                    next_state = ST_ALARM;
                else if (set_press)
                    next_state = (state == ST_SET_HOURS) ? ST_SET_MINUTES : ST_CLOCK;
            ST_ALARM, ST_ALARM_HOURS, ST_ALARM_MINUTES:
                if (mode_press)
                    next_state = ST_STOPWATCH;
                else if (set_press && state == ST_ALARM)
                    next_state = ST_ALARM_HOURS;
                else if (set_press)
                    next_state = (state == ST_ALARM_HOURS) ? ST_ALARM_MINUTES : ST_ALARM;
            ST_STOPWATCH:
                if (mode_press)
                    next_state = ST_CLOCK;
            ST_RINGING:
                if (down_press)
                    next_state = ST_CLOCK;
            default:
                next_state = ST_CLOCK;
        endcase
    end

    assign adjust_hours      = (state == ST_SET_HOURS);
    assign adjust_minutes    = (state == ST_SET_MINUTES);
    assign alarm_hours_sel   = (state == ST_ALARM_HOURS);
    assign alarm_minutes_sel = (state == ST_ALARM_MINUTES);
    // Arm only on the set that closes the alarm edit
    assign arm               = (state == ST_ALARM_MINUTES) && (next_state == ST_ALARM);
    assign disarm            = down_press && (state == ST_ALARM || state == ST_RINGING);
    assign sw_toggle         = set_press && (state == ST_STOPWATCH);
    assign sw_clear          = up_press && (state == ST_STOPWATCH);

    ////////////////////////////////////////////////////////////////////////////
    // Display multiplexer
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        next_screen = SCREEN_TIME;
        next_left   = field_t'(clock_hours);
        next_mid    = field_t'(clock_minutes);
        next_right  = field_t'(clock_seconds);
        case (state)
            ST_ALARM, ST_ALARM_HOURS, ST_ALARM_MINUTES:
            begin
                next_screen = SCREEN_ALARM;
                next_left   = field_t'(alarm_hours);
                next_mid    = field_t'(alarm_minutes);
                next_right  = '0;
            end
            ST_STOPWATCH:
            begin
                next_screen = SCREEN_STOPWATCH;
                next_left   = field_t'(sw_minutes);
                next_mid    = field_t'(sw_seconds);
                next_right  = sw_centis;
            end
            default:
                next_screen = SCREEN_TIME;
        endcase

        case (state)
            ST_SET_HOURS, ST_ALARM_HOURS:
                next_flash = 3'b100;
            ST_SET_MINUTES, ST_ALARM_MINUTES:
                next_flash = 3'b010;
            ST_RINGING:
                next_flash = 3'b111;
            default:
                next_flash = 3'b000;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state      <= ST_CLOCK;
            screen     <= SCREEN_TIME;
            flash      <= '0;
            disp_left  <= '0;
            disp_mid   <= '0;
            disp_right <= '0;
        end
        else
        begin
            state      <= next_state;
            screen     <= next_screen;
            flash      <= next_flash;
            disp_left  <= next_left;
            disp_mid   <= next_mid;
            disp_right <= next_right;
        end
    end

endmodule

// ==== rtl/stopwatch.sv ====
`timescale 1ns/1ps
`include "clock_macros.svh"

module stopwatch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                centi_tick,
    input  logic                sw_toggle,
    input  logic                sw_clear,
    output clock_pkg::minutes_t sw_minutes,
    output clock_pkg::minutes_t sw_seconds,
    output clock_pkg::centi_t   sw_centis
);
    import clock_pkg::*;

    logic running;
    logic at_limit;

    assign at_limit = (sw_minutes == `SW_LAST_MIN) && (sw_seconds == `SW_LAST_SEC)
                   && (sw_centis == `SW_LAST_CENTI);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            running    <= 1'b0;
            sw_minutes <= '0;
            sw_seconds <= '0;
            sw_centis  <= '0;
        end
        else
        begin
            if (sw_toggle)
                running <= !running;
            else if (at_limit)
                running <= 1'b0;

            if (sw_clear && !running)
            begin
                sw_minutes <= '0;
                sw_seconds <= '0;
                sw_centis  <= '0;
            end
            else if (running && centi_tick && !at_limit)
            begin
                if (sw_centis != `CENTI_PER_SEC - 1)
                    sw_centis <= sw_centis + 7'd1;
                else
                begin
                    sw_centis <= '0;
                    if (sw_seconds != `SEC_PER_MIN - 1)
                        sw_seconds <= sw_seconds + 6'd1;
                    else
                    begin
                        sw_seconds <= '0;
                        sw_minutes <= sw_minutes + 6'd1;
                    end
                end
            end
        end
    end

    a_centi_range: assert property (@(posedge clk) disable iff (!rst_n)
        sw_centis < `CENTI_PER_SEC)
    else
        $error("stopwatch centis out of range %0d", sw_centis);

endmodule

// ==== rtl/tick_divider.sv ====
`timescale 1ns/1ps
`include "clock_macros.svh"

module tick_divider (
    input  logic clk,
    input  logic rst_n,
    output logic centi_tick,
    output logic sec_tick
);
    import clock_pkg::*;

    logic [$clog2(`CLK_PER_CENTI)-1:0] pre_cnt;
    centi_t                            centi_cnt;
    logic                              pre_wrap;
    logic                              centi_wrap;

    assign pre_wrap   = (pre_cnt == `CLK_PER_CENTI - 1);
    assign centi_wrap = (centi_cnt == `CENTI_PER_SEC - 1);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pre_cnt   <= '0;
            centi_cnt <= '0;
        end
        else if (pre_wrap)
        begin
            pre_cnt   <= '0;
            centi_cnt <= centi_wrap ? '0 : centi_cnt + 7'd1;
        end
        else
        begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    assign centi_tick = pre_wrap;
    // Second tick lines up with the last centisecond of each second
    assign sec_tick   = pre_wrap && centi_wrap;

endmodule

// ==== rtl/time_counter.sv ====
`timescale 1ns/1ps
`include "clock_macros.svh"

module time_counter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sec_tick,
    input  logic                adjust_hours,
    input  logic                adjust_minutes,
    input  logic                up_press,
    input  logic                down_press,
    output clock_pkg::hours_t   hours,
    output clock_pkg::minutes_t minutes,
    output clock_pkg::minutes_t seconds
);
    import clock_pkg::*;

    logic step;
    logic sec_carry;
    logic min_carry;

    assign step      = up_press || down_press;
    assign sec_carry = (seconds == `SEC_PER_MIN - 1);
    assign min_carry = (minutes == `MIN_PER_HOUR - 1);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hours   <= '0;
            minutes <= '0;
            seconds <= '0;
        end
        else if (adjust_hours || adjust_minutes)
        begin
            // Seconds restart from zero once setting ends
            seconds <= '0;
            if (step && adjust_hours)
                hours <= hours_t'(wrap_step(field_t'(hours),
                                            field_t'(`HOURS_PER_DAY), up_press));
            else if (step && adjust_minutes)
                minutes <= minutes_t'(wrap_step(field_t'(minutes),
                                                field_t'(`MIN_PER_HOUR), up_press));
        end
        else if (sec_tick)
        begin
            seconds <= minutes_t'(wrap_step(field_t'(seconds), field_t'(`SEC_PER_MIN), 1'b1));
            if (sec_carry)
                minutes <= minutes_t'(wrap_step(field_t'(minutes),
                                                field_t'(`MIN_PER_HOUR), 1'b1));
            if (sec_carry && min_carry)
                hours <= hours_t'(wrap_step(field_t'(hours), field_t'(`HOURS_PER_DAY), 1'b1));
        end
    end

    a_time_range: assert property (@(posedge clk) disable iff (!rst_n)
        hours < `HOURS_PER_DAY && minutes < `MIN_PER_HOUR)
    else
        $error("time_counter out of range %0d:%0d", hours, minutes);

endmodule
